/* hw/synth_pkg.sv */
package synth_pkg;

	// Widths that carry a meaning through the design
	typedef logic [7:0] note_t;
	typedef logic [23:0] phase_inc_t;
	typedef logic [23:0] phase_t;
	typedef logic signed [15:0] sample_t;
	typedef logic [1:0] wave_sel_t;

	// AXI4-Lite port widths
	typedef logic [7:0] axil_addr_t;
	typedef logic [31:0] axil_data_t;
	typedef logic [3:0] axil_strb_t;
	typedef logic [1:0] axil_resp_t;

	localparam axil_resp_t resp_okay = 2'b00;
	localparam axil_resp_t resp_slverr = 2'b10;

	// Waveform choices
	localparam wave_sel_t wave_square = 2'd0;
	localparam wave_sel_t wave_saw = 2'd1;
	localparam wave_sel_t wave_triangle = 2'd2;
	localparam wave_sel_t wave_sine = 2'd3;

	// MIDI word as the processor writes it, top byte unused
	typedef struct packed {
		logic [7:0] unused;
		logic [3:0] status;
		logic [3:0] channel;
		note_t note;
		logic [7:0] value;
	} midi_msg_t;

	localparam logic [3:0] midi_note_on = 4'h9;
	localparam logic [3:0] midi_note_off = 4'h8;
	localparam logic [3:0] midi_pitch_bend = 4'hE;

	// Control FSM, 3-bit code also shows up in the status word
	typedef enum logic [2:0] {
		idle,
		base_lookup,
		next_lookup,
		playing
	} control_state_t;

	// Status word, increment field is bits 23:4 of the bent increment
	typedef struct packed {
		logic active;
		logic [2:0] state;
		note_t note;
		logic [19:0] inc_high;
	} synth_status_t;

	// Register map, word offsets
	localparam axil_addr_t reg_midi = 8'h00;
	localparam axil_addr_t reg_wave = 8'h04;
	localparam axil_addr_t reg_status = 8'h08;
	localparam axil_addr_t reg_increment = 8'h0C;
	localparam axil_addr_t reg_snapshot = 8'h10;

endpackage

/* hw/pitch_table.sv */
`timescale 1ns/10ps

module pitch_table import synth_pkg::*; (
	input note_t lookup_note,
	output phase_inc_t lookup_inc
);

	// Octave 10 increments, notes 120 to 131
	// 24-bit phase at a 48 kHz sample rate
	localparam phase_inc_t top_octave [12] = '{
		24'd2926232, 24'd3100235, 24'd3284584, 24'd3479896,
		24'd3686821, 24'd3906052, 24'd4138318, 24'd4384394,
		24'd4645104, 24'd4921316, 24'd5213951, 24'd5524015
	};

	note_t clamped;
	logic [3:0] octave;
	note_t semitone;

	always_comb begin
		// Anything past 127 plays note 127
		clamped = (lookup_note > 8'd127) ? 8'd127 : lookup_note;

		// Highest multiple of 12 not above the note
		octave = 4'd0;
		for (int o = 1; o <= 10; o++) begin
			if (clamped >= 8'(12 * o)) begin
				octave = 4'(o);
			end
		end
		semitone = clamped - 8'(12 * octave);

		// Each octave down halves the increment
		lookup_inc = top_octave[semitone[3:0]] >> (4'd10 - octave);
	end

endmodule

/* hw/synth_control.sv */
`timescale 1ns/10ps

module synth_control import synth_pkg::*; (
	input logic clock,
	input logic reset,
	input logic midi_valid,
	input midi_msg_t midi_msg,
	output note_t lookup_note,
	input phase_inc_t lookup_inc,
	output logic busy,
	output synth_status_t status,
	output phase_inc_t increment
);

	control_state_t state;
	note_t cur_note;
	logic active;
	// Unbent increment and gap to the next semitone
	phase_inc_t base_inc;
	phase_inc_t delta_inc;
	logic [7:0] bend_amount;
	logic [31:0] bend_scaled;
	phase_inc_t bent_inc;

	// Second lookup is for the semitone above
	assign lookup_note = (state == next_lookup) ? cur_note + 8'd1 : cur_note;
	assign busy = (state == base_lookup) || (state == next_lookup);

	// Bend by a sixteenth of the gap per step away from center
	always_comb begin
		if (midi_msg.value >= 8'd64) begin
			bend_amount = midi_msg.value - 8'd64;
		end else begin
			bend_amount = 8'd64 - midi_msg.value;
		end
		bend_scaled = (32'(bend_amount) * 32'(delta_inc)) >> 4;
		if (midi_msg.value >= 8'd64) begin
			bent_inc = base_inc + bend_scaled[23:0];
		end else begin
			bent_inc = base_inc - bend_scaled[23:0];
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= idle;
			cur_note <= '0;
			active <= 1'b0;
			increment <= '0;
		end else begin
			case (state)
				base_lookup: begin
					base_inc <= lookup_inc;
					state <= next_lookup;
				end
				next_lookup: begin
					delta_inc <= lookup_inc - base_inc;
					increment <= base_inc;
					active <= 1'b1;
					state <= playing;
				end
				default: begin
					if (midi_valid) begin
						case (midi_msg.status)
							midi_note_on: begin
								cur_note <= midi_msg.note;
								state <= base_lookup;
							end
							midi_note_off: begin
								// Only the sounding note silences the voice
								if (active && midi_msg.note == cur_note) begin
									active <= 1'b0;
									increment <= '0;
									state <= idle;
								end
							end
							midi_pitch_bend: begin
								if (active) begin
									increment <= bent_inc;
								end
							end
							default: begin
							end
						endcase
					end
				end
			endcase
		end
	end

	// Status snapshot for the register port
	assign status.active = active;
	assign status.state = state;
	assign status.note = cur_note;
	assign status.inc_high = increment[23:4];

endmodule

/* hw/synth_axil_regs.sv */
`timescale 1ns/10ps

module synth_axil_regs import synth_pkg::*; (
	input logic clock,
	input logic reset,
	// Write address and data
	input axil_addr_t awaddr,
	input logic awvalid,
	output logic awready,
	input axil_data_t wdata,
	input axil_strb_t wstrb,
	input logic wvalid,
	output logic wready,
	// Write response
	output axil_resp_t bresp,
	output logic bvalid,
	input logic bready,
	// Read address and data
	input axil_addr_t araddr,
	input logic arvalid,
	output logic arready,
	output axil_data_t rdata,
	output axil_resp_t rresp,
	output logic rvalid,
	input logic rready,
	// Control side
	input logic busy,
	input synth_status_t status,
	input phase_inc_t increment,
	input phase_t phase,
	input sample_t sample,
	output logic midi_valid,
	output midi_msg_t midi_msg,
	output wave_sel_t wave_sel
);

	logic write_fire;
	logic read_fire;
	logic write_known;
	logic read_known;

	// Address and data taken in the same cycle
	// Held off while a response waits or a note-on is still looking up
	assign awready = awvalid && wvalid && !bvalid && !busy;
	assign wready = awready;
	assign write_fire = awready;

	// One read outstanding at a time
	assign arready = !rvalid;
	assign read_fire = arvalid && arready;

	always_comb begin
		write_known = (awaddr == reg_midi) || (awaddr == reg_wave) ||
			(awaddr == reg_status) || (awaddr == reg_increment) ||
			(awaddr == reg_snapshot);
		read_known = (araddr == reg_midi) || (araddr == reg_wave) ||
			(araddr == reg_status) || (araddr == reg_increment) ||
			(araddr == reg_snapshot);
	end

	// Write channel, message pulse and wave select
	always_ff @(posedge clock) begin
		if (reset) begin
			bvalid <= 1'b0;
			midi_valid <= 1'b0;
			wave_sel <= wave_square;
		end else begin
			midi_valid <= 1'b0;
			if (write_fire) begin
				bvalid <= 1'b1;
				if (awaddr == reg_midi) begin
					midi_valid <= 1'b1;
				end
				if (awaddr == reg_wave && wstrb[0]) begin
					wave_sel <= wdata[1:0];
				end
			end else if (bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	// Payload side, no reset
	always_ff @(posedge clock) begin
		if (write_fire) begin
			bresp <= write_known ? resp_okay : resp_slverr;
			midi_msg <= wdata;
		end
	end

	// Read channel
	always_ff @(posedge clock) begin
		if (reset) begin
			rvalid <= 1'b0;
		end else if (read_fire) begin
			rvalid <= 1'b1;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

	// Read data, snapshot grabs phase and sample on the same edge
	always_ff @(posedge clock) begin
		if (read_fire) begin
			rresp <= read_known ? resp_okay : resp_slverr;
			case (araddr)
				reg_wave: rdata <= {30'd0, wave_sel};
				reg_status: rdata <= status;
				reg_increment: rdata <= {8'd0, increment};
				reg_snapshot: rdata <= {phase[23:8], sample};
				// Write-only MIDI word and holes read back as zero
				default: rdata <= '0;
			endcase
		end
	end

endmodule

/* hw/oscillator.sv */
`timescale 1ns/10ps

module oscillator import synth_pkg::*; #(
	parameter int sample_div = 16
) (
	input logic clock,
	input logic reset,
	input phase_inc_t increment,
	input wave_sel_t wave_sel,
	output phase_t phase,
	output sample_t sample
);

	localparam int count_bits = (sample_div > 1) ? $clog2(sample_div) : 1;

	logic [count_bits-1:0] tick_count;
	logic tick;
	logic [15:0] p;
	sample_t saw;
	logic [15:0] folded;
	sample_t tri_wave;
	logic signed [16:0] sine_gap;
	logic signed [32:0] sine_prod;

	// Sample tick divider
	assign tick = (tick_count == count_bits'(sample_div - 1));

	always_ff @(posedge clock) begin
		if (reset) begin
			tick_count <= '0;
			phase <= '0;
		end else begin
			if (tick) begin
				tick_count <= '0;
				phase <= phase + increment;
			end else begin
				tick_count <= tick_count + 1'b1;
			end
		end
	end

	// Top 16 phase bits drive all four shapes
	assign p = phase[23:8];

	always_comb begin
		// Saw is p offset by half scale
		saw = {~p[15], p[14:0]};

		// Fold negative half onto positive, 0 to 32767
		folded = saw[15] ? ~saw : saw;
		// Double and recenter
		tri_wave = {~folded[14], folded[13:0], 1'b0};

		// Parabola 4t(1-|t|), gap uses the folded value so the peak stays in range
		sine_gap = 17'sd32767 - $signed({1'b0, folded});
		sine_prod = saw * sine_gap;

		case (wave_sel)
			wave_square: sample = p[15] ? -16'sd32768 : 16'sd32767;
			wave_saw: sample = saw;
			wave_triangle: sample = tri_wave;
			// Product over 2^13 gives the factor of four
			default: sample = sine_prod[28:13];
		endcase
	end

endmodule

/* hw/pwm_modulator.sv */
`timescale 1ns/10ps

module pwm_modulator import synth_pkg::*; #(
	parameter int pwm_bits = 8
) (
	input logic clock,
	input logic reset,
	input sample_t sample,
	output logic audio_pwm,
	output logic audio_enable
);

	logic [pwm_bits-1:0] count;
	logic [pwm_bits-1:0] level;
	logic [pwm_bits-1:0] next_level;

	// Offset binary from the top sample bits
	assign next_level = {~sample[15], sample[14 -: pwm_bits-1]};

	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
			level <= '0;
		end else begin
			count <= count + 1'b1;
			// New level takes over as the counter wraps to zero
			if (count == '1) begin
				level <= next_level;
			end
		end
	end

	// Level high cycles per period
	assign audio_pwm = (count < level);

	// Amplifier shutdown released out of reset
	assign audio_enable = !reset;

endmodule

/* hw/midi_synth.sv */
`timescale 1ns/10ps

module midi_synth import synth_pkg::*; #(
	parameter int sample_div = 16,
	parameter int pwm_bits = 8
) (
	input logic clock,
	input logic reset,
	// AXI4-Lite slave
	input axil_addr_t awaddr,
	input logic awvalid,
	output logic awready,
	input axil_data_t wdata,
	input axil_strb_t wstrb,
	input logic wvalid,
	output logic wready,
	output axil_resp_t bresp,
	output logic bvalid,
	input logic bready,
	input axil_addr_t araddr,
	input logic arvalid,
	output logic arready,
	output axil_data_t rdata,
	output axil_resp_t rresp,
	output logic rvalid,
	input logic rready,
	// Audio pins
	output logic audio_pwm,
	output logic audio_enable
);

	logic midi_valid;
	midi_msg_t midi_msg;
	wave_sel_t wave_sel;
	logic busy;
	synth_status_t status;
	phase_inc_t increment;
	note_t lookup_note;
	phase_inc_t lookup_inc;
	phase_t phase;
	sample_t sample;

	// Register port
	synth_axil_regs u_regs (
		.clock(clock), .reset(reset),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.busy(busy), .status(status), .increment(increment),
		.phase(phase), .sample(sample),
		.midi_valid(midi_valid), .midi_msg(midi_msg), .wave_sel(wave_sel)
	);

	// Note handling
	synth_control u_control (
		.clock(clock), .reset(reset),
		.midi_valid(midi_valid), .midi_msg(midi_msg),
		.lookup_note(lookup_note), .lookup_inc(lookup_inc),
		.busy(busy), .status(status), .increment(increment)
	);

	pitch_table u_pitch_table (
		.lookup_note(lookup_note),
		.lookup_inc(lookup_inc)
	);

	// Datapath to the pin
	oscillator #(.sample_div(sample_div)) u_oscillator (
		.clock(clock), .reset(reset),
		.increment(increment), .wave_sel(wave_sel),
		.phase(phase), .sample(sample)
	);

	pwm_modulator #(.pwm_bits(pwm_bits)) u_pwm (
		.clock(clock), .reset(reset),
		.sample(sample),
		.audio_pwm(audio_pwm), .audio_enable(audio_enable)
	);

endmodule

/* bench/midi_synth_tb.sv */
`timescale 1ns/10ps

module midi_synth_tb import synth_pkg::*; ();

	localparam int sample_div = 16;
	localparam int pwm_bits = 8;
	localparam int pwm_period = 1 << pwm_bits;
	// Longest handshake is a write held off by a note-on
	localparam int wait_limit = 64;
	localparam int bend_sweeps = 12;

	logic clock;
	logic reset;
	axil_addr_t awaddr;
	logic awvalid;
	logic awready;
	axil_data_t wdata;
	axil_strb_t wstrb;
	logic wvalid;
	logic wready;
	axil_resp_t bresp;
	logic bvalid;
	logic bready;
	axil_addr_t araddr;
	logic arvalid;
	logic arready;
	axil_data_t rdata;
	axil_resp_t rresp;
	logic rvalid;
	logic rready;
	logic audio_pwm;
	logic audio_enable;

	// Generator state for bend values
	logic [31:0] lcg_state;

	midi_synth #(.sample_div(sample_div), .pwm_bits(pwm_bits)) u_midi_synth (
		.clock(clock), .reset(reset),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.audio_pwm(audio_pwm), .audio_enable(audio_enable)
	);

	// 8 ns clock
	initial begin
		clock = 1'b0;
		forever begin
			#4 clock = ~clock;
		end
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			abort_run($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
		end
	endtask

	function automatic logic [31:0] lcg_next(input logic [31:0] value);
		return value * 32'd1664525 + 32'd1013904223;
	endfunction

	// OKAY only for the five mapped words
	function automatic axil_resp_t map_resp(input axil_addr_t offset);
		case (offset)
			reg_midi, reg_wave, reg_status, reg_increment, reg_snapshot: return resp_okay;
			default: return resp_slverr;
		endcase
	endfunction

	// Waveform from the top 16 phase bits
	function automatic int wave_sample(input int wave, input int p);
		int saw;
		int fold;
		saw = p - 32768;
		// Negative half mirrored onto 0 to 32767
		if (saw < 0) begin
			fold = -saw - 1;
		end else begin
			fold = saw;
		end
		case (wave)
			0: return (p < 32768) ? 32767 : -32768;
			1: return saw;
			2: return 2 * fold - 32768;
			// 4t(1-|t|) at full scale
			default: return (saw * (32767 - fold)) >>> 13;
		endcase
	endfunction

	// Offset binary level from the top pwm_bits bits
	function automatic int pwm_level(input int sample);
		return (sample + 32768) >> (16 - pwm_bits);
	endfunction

	// Sixteenth of the semitone gap per step from center
	function automatic logic [23:0] bend_increment(input int value, input logic [23:0] base,
			input logic [23:0] next);
		longint gap;
		gap = longint'(next) - longint'(base);
		if (value >= 64) begin
			return 24'(longint'(base) + (((value - 64) * gap) >> 4));
		end else begin
			return 24'(longint'(base) - (((64 - value) * gap) >> 4));
		end
	endfunction

	task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
			output axil_resp_t resp);
		int cycles;
		@(posedge clock);
		awaddr <= addr;
		awvalid <= 1'b1;
		wdata <= data;
		wstrb <= 4'hF;
		wvalid <= 1'b1;
		bready <= 1'b1;
		cycles = 0;
		@(negedge clock);
		while (!(awready && wready)) begin
			cycles++;
			if (cycles > wait_limit) begin
				abort_run($sformatf("write to %h was never accepted", addr));
			end
			@(negedge clock);
		end
		// Accepted on this edge
		@(posedge clock);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		cycles = 0;
		@(negedge clock);
		while (!bvalid) begin
			cycles++;
			if (cycles > wait_limit) begin
				abort_run($sformatf("no write response for %h", addr));
			end
			@(negedge clock);
		end
		resp = bresp;
		@(posedge clock);
		bready <= 1'b0;
	endtask

	task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
			output axil_resp_t resp);
		int cycles;
		@(posedge clock);
		araddr <= addr;
		arvalid <= 1'b1;
		rready <= 1'b1;
		cycles = 0;
		@(negedge clock);
		while (!arready) begin
			cycles++;
			if (cycles > wait_limit) begin
				abort_run($sformatf("read of %h was never accepted", addr));
			end
			@(negedge clock);
		end
		@(posedge clock);
		arvalid <= 1'b0;
		cycles = 0;
		@(negedge clock);
		while (!rvalid) begin
			cycles++;
			if (cycles > wait_limit) begin
				abort_run($sformatf("no read data for %h", addr));
			end
			@(negedge clock);
		end
		data = rdata;
		resp = rresp;
		@(posedge clock);
		rready <= 1'b0;
	endtask

	// Poll status until the FSM is out of its lookup states
	task automatic wait_control_settled();
		axil_data_t data;
		axil_resp_t resp;
		int polls;
		polls = 0;
		axil_read(reg_status, data, resp);
		while (data[30:28] == base_lookup || data[30:28] == next_lookup) begin
			polls++;
			if (polls > wait_limit) begin
				abort_run("control FSM stayed in its lookup states");
			end
			axil_read(reg_status, data, resp);
		end
	endtask

	task automatic apply_bend(input string name, input logic [7:0] value,
			input logic [23:0] base, input logic [23:0] next);
		axil_data_t data;
		axil_resp_t resp;
		axil_write(reg_midi, {8'h00, midi_pitch_bend, 4'h0, 8'h00, value}, resp);
		check({name, " bresp"}, 32'(resp_okay), 32'(resp));
		wait_control_settled();
		axil_read(reg_increment, data, resp);
		check($sformatf("%s bend %0d", name, value), {8'd0, bend_increment(value, base, next)},
			data);
	endtask

	// Center, both ends, random values, back to center
	task automatic run_bend_sweep(input string name, input logic [23:0] base,
			input logic [23:0] next);
		apply_bend(name, 8'd64, base, next);
		apply_bend(name, 8'd0, base, next);
		apply_bend(name, 8'd127, base, next);
		for (int i = 0; i < bend_sweeps; i++) begin
			lcg_state = lcg_next(lcg_state);
			apply_bend(name, {1'b0, lcg_state[30:24]}, base, next);
		end
		apply_bend(name, 8'd64, base, next);
	endtask

	task automatic check_snapshots(input string name, input int wave, input int count);
		axil_data_t data;
		axil_resp_t resp;
		int expected;
		for (int i = 0; i < count; i++) begin
			axil_read(reg_snapshot, data, resp);
			check({name, " rresp"}, 32'(resp_okay), 32'(resp));
			// Phase and sample come from the same edge
			expected = wave_sample(wave, int'(data[31:16]));
			check($sformatf("%s sample %0d phase %h", name, i, data[31:16]), 32'(expected),
				32'($signed(data[15:0])));
		end
	endtask

	task automatic check_pwm(input string name, input int windows);
		axil_data_t first;
		axil_data_t last;
		axil_resp_t resp;
		int level;
		int high;
		// Let the level latch at least once after the last change
		repeat (pwm_period + sample_div) @(posedge clock);
		axil_read(reg_snapshot, first, resp);
		level = pwm_level($signed(first[15:0]));
		check({name, " enable"}, 32'd1, 32'(audio_enable));
		for (int w = 0; w < windows; w++) begin
			high = 0;
			repeat (pwm_period) begin
				@(negedge clock);
				if (audio_pwm) begin
					high++;
				end
			end
			check($sformatf("%s window %0d", name, w), level, high);
		end
		// Silent voice keeps phase and sample frozen
		axil_read(reg_snapshot, last, resp);
		check({name, " hold"}, first, last);
	endtask

	task automatic run_step(input int step, input logic [63:0] op, input axil_addr_t offset,
			input logic [31:0] data, input logic [31:0] expected);
		axil_data_t actual;
		axil_resp_t resp;
		string name;
		name = $sformatf("step %0d at %h", step, offset);
		if (op == "write") begin
			axil_write(offset, data, resp);
			check({name, " bresp"}, expected, 32'(resp));
			// MIDI word kicks off the control FSM
			if (offset == reg_midi) begin
				wait_control_settled();
			end
		end else if (op == "read") begin
			axil_read(offset, actual, resp);
			check({name, " rresp"}, 32'(map_resp(offset)), 32'(resp));
			check({name, " rdata"}, expected, actual);
		end else if (op == "snap") begin
			check_snapshots(name, data, expected);
		end else if (op == "bend") begin
			run_bend_sweep(name, data[23:0], expected[23:0]);
		end else if (op == "pwm") begin
			check_pwm(name, expected);
		end else begin
			abort_run($sformatf("unknown operation in the case file at step %0d", step));
		end
	endtask

	initial begin
		int fd;
		int code;
		int step;
		logic [63:0] op;
		logic [8*128-1:0] rest;
		axil_addr_t offset;
		logic [31:0] data;
		logic [31:0] expected;

		reset <= 1'b1;
		awaddr <= '0;
		awvalid <= 1'b0;
		wdata <= '0;
		wstrb <= '0;
		wvalid <= 1'b0;
		bready <= 1'b0;
		araddr <= '0;
		arvalid <= 1'b0;
		rready <= 1'b0;
		lcg_state = 32'h3737cf8e;
		repeat (3) @(posedge clock);
		// Amplifier stays shut down while reset is held
		check("reset audio_enable", 32'd0, 32'(audio_enable));
		reset <= 1'b0;
		@(negedge clock);
		check("reset bvalid", 32'd0, 32'(bvalid));
		check("reset rvalid", 32'd0, 32'(rvalid));
		check("reset audio_pwm", 32'd0, 32'(audio_pwm));

		fd = $fopen("bench/synth_cases.txt", "r");
		if (fd == 0) begin
			abort_run("could not open bench/synth_cases.txt");
		end
		step = 0;
		code = $fscanf(fd, "%s", op);
		while (code == 1) begin
			// Comment lines start with a lone hash
			if (op == "#") begin
				code = $fgets(rest, fd);
			end else begin
				code = $fscanf(fd, "%h %h %h", offset, data, expected);
				if (code != 3) begin
					abort_run($sformatf("malformed case line after step %0d", step));
				end
				step++;
				run_step(step, op, offset, data, expected);
			end
			code = $fscanf(fd, "%s", op);
		end
		$fclose(fd);
		if (step == 0) begin
			abort_run("the case file held no steps");
		end
		$display("test passed");
		$finish;
	end

endmodule

/* bench/synth_cases.txt */
# op offset data expected, hex; write expects bresp, read expects rdata
# snap: data wave, expected count; bend: data base, expected next inc; pwm: expected windows
read 0c 0 00000000
read 08 0 00000000
write 00 00901540 0
read 0c 0 0000258b
read 08 0 b1500258
write 00 00906440 0
read 0c 0 000e1069
read 08 0 b640e106
write 00 00907f40 0
read 0c 0 0042e68a
read 08 0 b7f42e68
write 00 00903c40 0
read 0c 0 00016534
read 08 0 b3c01653
bend 0c 00016534 00017a72
write 04 00000000 0
read 04 0 00000000
snap 10 0 8
write 04 00000001 0
snap 10 1 8
write 04 00000002 0
snap 10 2 8
write 04 00000003 0
read 04 0 00000003
snap 10 3 8
write 00 00803d00 0
read 08 0 b3c01653
read 0c 0 00016534
write 00 00803c00 0
read 08 0 03c00000
read 0c 0 00000000
pwm 10 0 3
write 04 00000000 0
pwm 10 0 2
write 04 00000001 0
pwm 10 0 2
write 04 00000002 0
pwm 10 0 2
write 14 00000000 2
write 40 12345678 2
read 14 0 00000000
read fc 0 00000000
read 00 0 00000000

/* sources.f */
hw/synth_pkg.sv
hw/pitch_table.sv
hw/synth_control.sv
hw/synth_axil_regs.sv
hw/oscillator.sv
hw/pwm_modulator.sv
hw/midi_synth.sv
bench/midi_synth_tb.sv

/* Bender.yml */
package:
  name: midi_synth

sources:
  - hw/synth_pkg.sv
  - hw/pitch_table.sv
  - hw/synth_control.sv
  - hw/synth_axil_regs.sv
  - hw/oscillator.sv
  - hw/pwm_modulator.sv
  - hw/midi_synth.sv
  - target: test
    files:
      - bench/midi_synth_tb.sv
